// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module mem_subsys_tb -f src.f -o mem_subsys_sim

run: compile
	./obj_dir/mem_subsys_sim

clean:
	rm -rf obj_dir

// ==== design/bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  mem_pkg::bus_req_t   unc_bus_req,
    input  logic                unc_bus_req_valid,
    output logic                unc_bus_req_ready,
    output logic                unc_bus_resp_valid,
    input  mem_pkg::bus_req_t   dc_bus_req,
    input  logic                dc_bus_req_valid,
    output logic                dc_bus_req_ready,
    output logic                dc_bus_resp_valid,
    output mem_pkg::bus_req_t   bus_req,
    output logic                bus_req_valid,
    input  logic                bus_req_ready,
    input  logic                bus_resp_valid
);

    logic held_q;       // a grant is held
    logic held_unc_q;   // which master holds it
    logic wait_q;       // request accepted, response pending
    logic pick_unc;

    // uncached master wins when nothing is held
    assign pick_unc = held_q ? held_unc_q : unc_bus_req_valid;

    assign bus_req       = pick_unc ? unc_bus_req : dc_bus_req;
    assign bus_req_valid = !wait_q && (pick_unc ? unc_bus_req_valid : dc_bus_req_valid);

    assign unc_bus_req_ready = !wait_q && pick_unc && bus_req_ready;
    assign dc_bus_req_ready  = !wait_q && !pick_unc && bus_req_ready;

    assign unc_bus_resp_valid = wait_q && held_unc_q && bus_resp_valid;
    assign dc_bus_resp_valid  = wait_q && !held_unc_q && bus_resp_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_q <= 1'b0;
            wait_q <= 1'b0;
        end else if (wait_q && bus_resp_valid) begin
            held_q <= 1'b0;
            wait_q <= 1'b0;
        end else begin
            if (!held_q && (unc_bus_req_valid || dc_bus_req_valid))
                held_q <= 1'b1;
            if (bus_req_valid && bus_req_ready)
                wait_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!held_q)
            held_unc_q <= unc_bus_req_valid;
    end

endmodule

// ==== design/dcache.sv ====
`timescale 1ns/100ps

module dcache (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fence,
    input  mem_pkg::core_req_t    cache_req,
    input  logic                  cache_req_valid,
    output logic                  cache_req_ready,
    output mem_pkg::core_resp_t   cache_resp,
    output logic                  cache_resp_valid,
    output mem_pkg::bus_req_t     dc_bus_req,
    output logic                  dc_bus_req_valid,
    input  logic                  dc_bus_req_ready,
    input  mem_pkg::bus_resp_t    dc_bus_resp,
    input  logic                  dc_bus_resp_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_drain_wait,
        st_refill_req,
        st_refill_wait
    } state_e;

    logic [mem_pkg::tag_w-1:0]        tag_q  [mem_pkg::line_count];
    logic [mem_pkg::data_w-1:0]       data_q [mem_pkg::line_count];
    logic [mem_pkg::line_count-1:0]   valid_q;

    state_e                           state_q;
    logic [mem_pkg::addr_w-1:0]       miss_addr_q;
    logic                             resp_valid_q;
    logic [mem_pkg::data_w-1:0]       resp_data_q;

    logic                             sb_valid_q;  // posted store waiting or in flight
    logic                             sb_sent_q;   // posted store accepted by the bus
    mem_pkg::bus_req_t                sb_req_q;

    logic [mem_pkg::index_w-1:0]      idx;
    logic [mem_pkg::index_w-1:0]      fill_idx;
    logic [mem_pkg::tag_w-1:0]        tag;
    logic [mem_pkg::strb_w-1:0]       strb;
    logic                             hit;
    logic                             is_store;
    logic                             accept;
    logic                             fill;

    assign idx      = cache_req.addr[mem_pkg::offset_w +: mem_pkg::index_w];   // bits 6:3
    assign tag      = cache_req.addr[mem_pkg::addr_w-1 -: mem_pkg::tag_w];
    assign fill_idx = miss_addr_q[mem_pkg::offset_w +: mem_pkg::index_w];
    assign strb     = mem_pkg::size_strobe(cache_req.size,
                                           cache_req.addr[mem_pkg::offset_w-1:0]);
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);
    assign is_store = (cache_req.op == mem_pkg::mem_store);
    assign fill     = (state_q == st_refill_wait) && dc_bus_resp_valid;

    // a store needs the buffer free, a load can always be taken when idle
    assign cache_req_ready = (state_q == st_idle) && !(is_store && sb_valid_q);
    assign accept          = cache_req_valid && cache_req_ready;

    assign cache_resp_valid = resp_valid_q;
    assign cache_resp.rdata = resp_data_q;

    // refill only starts once the buffer is empty, so the two never compete
    assign dc_bus_req_valid = (sb_valid_q && !sb_sent_q) || (state_q == st_refill_req);

    always_comb begin
        dc_bus_req = sb_req_q;
        if (state_q == st_refill_req) begin
            dc_bus_req.write = 1'b0;
            dc_bus_req.size  = mem_pkg::size_dword;
            dc_bus_req.addr  = {miss_addr_q[mem_pkg::addr_w-1:mem_pkg::offset_w],
                                {mem_pkg::offset_w{1'b0}}};
            dc_bus_req.wdata = '0;
            dc_bus_req.wstrb = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q      <= st_idle;
            valid_q      <= '0;
            resp_valid_q <= 1'b0;
            sb_valid_q   <= 1'b0;
            sb_sent_q    <= 1'b0;
        end else begin
            resp_valid_q <= 1'b0;
            if (sb_valid_q && !sb_sent_q && dc_bus_req_ready)
                sb_sent_q <= 1'b1;
            if (sb_sent_q && dc_bus_resp_valid) begin  // write acknowledged
                sb_valid_q <= 1'b0;
                sb_sent_q  <= 1'b0;
            end
            case (state_q)
                st_idle: begin
                    if (accept && is_store) begin
                        sb_valid_q   <= 1'b1;
                        resp_valid_q <= 1'b1;
                    end else if (accept && hit) begin
                        resp_valid_q <= 1'b1;
                    end else if (accept) begin
                        state_q <= sb_valid_q ? st_drain_wait : st_refill_req;
                    end
                end
                st_drain_wait: begin
                    if (!sb_valid_q)
                        state_q <= st_refill_req;
                end
                st_refill_req: begin
                    if (dc_bus_req_ready)
                        state_q <= st_refill_wait;
                end
                default: begin
                    if (fill) begin
                        state_q           <= st_idle;
                        resp_valid_q      <= 1'b1;
                        valid_q[fill_idx] <= 1'b1;
                    end
                end
            endcase
            if (fence)
                valid_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            miss_addr_q <= cache_req.addr;
            resp_data_q <= data_q[idx];
        end
        if (accept && is_store) begin
            sb_req_q.write <= 1'b1;
            sb_req_q.size  <= mem_pkg::size_dword;
            sb_req_q.addr  <= {cache_req.addr[mem_pkg::addr_w-1:mem_pkg::offset_w],
                               {mem_pkg::offset_w{1'b0}}};
            sb_req_q.wdata <= cache_req.wdata;
            sb_req_q.wstrb <= strb;
            for (int b = 0; b < mem_pkg::strb_w; b++) begin
                if (hit && strb[b])
                    data_q[idx][8*b +: 8] <= cache_req.wdata[8*b +: 8];
            end
        end
        if (fill) begin
            data_q[fill_idx] <= dc_bus_resp.rdata;
            tag_q[fill_idx]  <= miss_addr_q[mem_pkg::addr_w-1 -: mem_pkg::tag_w];
            resp_data_q      <= dc_bus_resp.rdata;
        end
    end

endmodule

// ==== design/mem_pkg.sv ====
package mem_pkg;

    localparam int addr_w     = 32;
    localparam int data_w     = 64;
    localparam int strb_w     = data_w / 8;
    localparam int line_count = 16;
    localparam int offset_w   = $clog2(strb_w);          // byte offset inside a dword
    localparam int index_w    = $clog2(line_count);
    localparam int tag_w      = addr_w - index_w - offset_w;

    typedef enum logic {
        mem_load,
        mem_store
    } mem_op_e;

    // same codes as the AXI size field
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_half  = 2'd1,
        size_word  = 2'd2,
        size_dword = 2'd3
    } mem_size_e;

    // wdata sits in its byte lanes, rdata is always the whole dword
    typedef struct packed {
        mem_op_e               op;
        mem_size_e             size;
        logic [addr_w-1:0]     addr;
        logic [data_w-1:0]     wdata;
    } core_req_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;
    } core_resp_t;

    typedef struct packed {
        logic                  write;
        mem_size_e             size;
        logic [addr_w-1:0]     addr;
        logic [data_w-1:0]     wdata;
        logic [strb_w-1:0]     wstrb;
    } bus_req_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;
    } bus_resp_t;

    // byte lanes touched by an access of this size at this offset
    function automatic logic [strb_w-1:0] size_strobe(mem_size_e size,
                                                      logic [offset_w-1:0] offset);
        logic [strb_w-1:0] base;
        case (size)
            size_byte: base = 8'h01;
            size_half: base = 8'h03;
            size_word: base = 8'h0f;
            default:   base = 8'hff;
        endcase
        return base << offset;
    endfunction

    function automatic logic [addr_w-1:0] align_addr(mem_size_e size, logic [addr_w-1:0] addr);
        logic [addr_w-1:0] low;
        low = (addr_w'(1) << size) - addr_w'(1);
        return addr & ~low;
    endfunction

endpackage

// ==== design/mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fence,
    input  mem_pkg::core_req_t    core_req,
    input  logic                  core_req_valid,
    output logic                  core_req_ready,
    output mem_pkg::core_resp_t   core_resp,
    output logic                  core_resp_valid,
    output mem_pkg::bus_req_t     bus_req,
    output logic                  bus_req_valid,
    input  logic                  bus_req_ready,
    input  mem_pkg::bus_resp_t    bus_resp,
    input  logic                  bus_resp_valid
);

    mem_pkg::core_req_t    cache_req;
    logic                  cache_req_valid;
    logic                  cache_req_ready;
    mem_pkg::core_resp_t   cache_resp;
    logic                  cache_resp_valid;

    mem_pkg::bus_req_t     unc_bus_req;
    logic                  unc_bus_req_valid;
    logic                  unc_bus_req_ready;
    logic                  unc_bus_resp_valid;

    mem_pkg::bus_req_t     dc_bus_req;
    logic                  dc_bus_req_valid;
    logic                  dc_bus_req_ready;
    logic                  dc_bus_resp_valid;

    // both masters see the read data, only the owner gets the strobe
    uncache_mmio u_uncache_mmio (
        .unc_bus_resp (bus_resp),
        .*
    );

    dcache u_dcache (
        .dc_bus_resp (bus_resp),
        .*
    );

    bus_arbiter u_bus_arbiter (.*);

endmodule

// ==== design/uncache_mmio.sv ====
`timescale 1ns/100ps
`include "mem_map.svh"

module uncache_mmio (
    input  logic                  clk,
    input  logic                  reset,
    input  mem_pkg::core_req_t    core_req,
    input  logic                  core_req_valid,
    output logic                  core_req_ready,
    output mem_pkg::core_resp_t   core_resp,
    output logic                  core_resp_valid,
    output mem_pkg::core_req_t    cache_req,
    output logic                  cache_req_valid,
    input  logic                  cache_req_ready,
    input  mem_pkg::core_resp_t   cache_resp,
    input  logic                  cache_resp_valid,
    output mem_pkg::bus_req_t     unc_bus_req,
    output logic                  unc_bus_req_valid,
    input  logic                  unc_bus_req_ready,
    input  mem_pkg::bus_resp_t    unc_bus_resp,
    input  logic                  unc_bus_resp_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_cached,
        st_unc_req,
        st_unc_wait
    } state_e;

    state_e                           state_q;
    logic                             active_q;   // low until the first cycle after reset
    logic                             is_mmio;
    logic                             core_accept;
    logic [mem_pkg::addr_w-1:0]       aligned_addr;
    mem_pkg::bus_req_t                unc_req_q;

    assign is_mmio = `IN_RANGE(core_req.addr, `MMIO_UART_START, `MMIO_UART_END)
                  || `IN_RANGE(core_req.addr, `MMIO_SPICTRL_START, `MMIO_SPICTRL_END)
                  || `IN_RANGE(core_req.addr, `MMIO_SPI_START, `MMIO_SPI_END)
                  || `IN_RANGE(core_req.addr, `MMIO_CLINT_START, `MMIO_CLINT_END);

    assign aligned_addr = mem_pkg::align_addr(core_req.size, core_req.addr);

    assign core_req_ready  = active_q && (state_q == st_idle) && (is_mmio || cache_req_ready);
    assign core_accept     = core_req_valid && core_req_ready;

    // cached accesses go straight through to the dcache
    assign cache_req       = core_req;
    assign cache_req_valid = active_q && (state_q == st_idle) && core_req_valid && !is_mmio;

    assign unc_bus_req       = unc_req_q;
    assign unc_bus_req_valid = (state_q == st_unc_req);

    always_comb begin
        if (state_q == st_unc_wait) begin
            core_resp_valid = unc_bus_resp_valid;
            core_resp.rdata = unc_bus_resp.rdata;
        end else begin
            core_resp_valid = (state_q == st_cached) && cache_resp_valid;
            core_resp       = cache_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= st_idle;
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
            case (state_q)
                st_idle: begin
                    if (core_accept)
                        state_q <= is_mmio ? st_unc_req : st_cached;
                end
                st_cached: begin
                    if (cache_resp_valid)
                        state_q <= st_idle;
                end
                st_unc_req: begin
                    if (unc_bus_req_ready)
                        state_q <= st_unc_wait;
                end
                default: begin
                    if (unc_bus_resp_valid)
                        state_q <= st_idle;
                end
            endcase
        end
    end

    // one aligned, sized transfer per device access
    always_ff @(posedge clk) begin
        if (core_accept && is_mmio) begin
            unc_req_q.write <= (core_req.op == mem_pkg::mem_store);
            unc_req_q.size  <= core_req.size;
            unc_req_q.addr  <= aligned_addr;
            unc_req_q.wdata <= core_req.wdata;
            unc_req_q.wstrb <= mem_pkg::size_strobe(core_req.size,
                                                    aligned_addr[mem_pkg::offset_w-1:0]);
        end
    end

endmodule

// ==== include/mem_map.svh ====
`ifndef MEM_MAP_SVH
`define MEM_MAP_SVH

`define MMIO_UART_START     32'h1000_0000
`define MMIO_UART_END       32'h1000_0fff
`define MMIO_SPICTRL_START  32'h1000_1000
`define MMIO_SPICTRL_END    32'h1000_1fff
`define MMIO_SPI_START      32'h3000_0000
`define MMIO_SPI_END        32'h3fff_ffff
`define MMIO_CLINT_START    32'h0200_0000
`define MMIO_CLINT_END      32'h0200_ffff
`define RAM_START           32'h8000_0000

// inclusive range test
`define IN_RANGE(a, lo, hi) (((a) >= (lo)) && ((a) <= (hi)))

`endif

// ==== src.f ====
+incdir+include
design/mem_pkg.sv
design/uncache_mmio.sv
design/dcache.sv
design/bus_arbiter.sv
design/mem_subsys_top.sv
test/mem_subsys_chk.sv
test/mem_subsys_tb.sv

// ==== test/mem_subsys_chk.sv ====
`timescale 1ns/100ps

module mem_subsys_chk (
    input logic                 clk,
    input logic                 reset,
    input mem_pkg::core_req_t   core_req,
    input logic                 core_req_valid,
    input logic                 core_req_ready,
    input logic                 core_resp_valid,
    input mem_pkg::bus_req_t    bus_req,
    input logic                 bus_req_valid,
    input logic                 bus_req_ready,
    input logic                 bus_resp_valid
);

    logic core_busy_q;   // core request accepted, response not yet seen
    logic bus_busy_q;    // bus request accepted, response not yet seen

    always_ff @(posedge clk) begin
        if (reset) begin
            core_busy_q <= 1'b0;
            bus_busy_q  <= 1'b0;
        end else begin
            if (core_req_valid && core_req_ready)
                core_busy_q <= 1'b1;
            else if (core_resp_valid)
                core_busy_q <= 1'b0;
            if (bus_req_valid && bus_req_ready)
                bus_busy_q <= 1'b1;
            else if (bus_resp_valid)
                bus_busy_q <= 1'b0;
        end
    end

    core_hold: assert property (@(posedge clk) disable iff (reset)
        core_req_valid && !core_req_ready |=> core_req_valid && $stable(core_req))
        else $error("core request changed while stalled");

    bus_hold: assert property (@(posedge clk) disable iff (reset)
        bus_req_valid && !bus_req_ready |=> bus_req_valid && $stable(bus_req))
        else $error("bus request changed while stalled");

    bus_single: assert property (@(posedge clk) disable iff (reset)
        bus_req_valid && bus_req_ready |-> !bus_busy_q)
        else $error("second bus request accepted before the response");

    resp_follows: assert property (@(posedge clk) disable iff (reset)
        core_resp_valid |-> core_busy_q)
        else $error("core response without an accepted request");

endmodule

bind mem_subsys_top mem_subsys_chk u_mem_subsys_chk (.*);

// ==== test/mem_subsys_tb.sv ====
`timescale 1ns/100ps
`include "mem_map.svh"

module mem_subsys_tb;

    localparam int num_requests   = 2000;
    localparam int max_bus_delay  = 5;
    // worst case per request is a store drain plus a refill under back-pressure
    localparam int cycles_per_req = 2 * (max_bus_delay + 12) + 4;
    localparam longint watchdog_ns = longint'(num_requests * cycles_per_req + 1000) * 10;

    typedef struct packed {
        logic        is_load;
        logic [63:0] data;
        logic [63:0] mask;
    } exp_resp_t;

    logic                 clk;
    logic                 reset;
    logic                 fence;
    mem_pkg::core_req_t   core_req;
    logic                 core_req_valid;
    logic                 core_req_ready;
    mem_pkg::core_resp_t  core_resp;
    logic                 core_resp_valid;
    mem_pkg::bus_req_t    bus_req;
    logic                 bus_req_valid;
    logic                 bus_req_ready = 1'b0;
    mem_pkg::bus_resp_t   bus_resp = '0;
    logic                 bus_resp_valid = 1'b0;

    logic [7:0]           ref_mem [logic [31:0]];   // byte-addressed reference model
    logic [63:0]          bus_mem [logic [28:0]];   // dword-addressed bus memory
    logic                 line_valid [16];
    logic [24:0]          line_tag [16];
    mem_pkg::bus_req_t    unc_exp [$];
    mem_pkg::bus_req_t    dc_exp [$];
    exp_resp_t            resp_exp [$];

    mem_subsys_top u_mem_subsys_top (.*);

    // every byte mixes all four address bytes
    function automatic logic [7:0] fill_byte(logic [31:0] addr);
        return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h3c;
    endfunction

    function automatic logic [63:0] fill_dword(logic [28:0] dw);
        logic [63:0] d;
        for (int b = 0; b < 8; b++)
            d[8*b +: 8] = fill_byte({dw, 3'(b)});
        return d;
    endfunction

    function automatic logic [7:0] access_strobe(logic [1:0] size, logic [2:0] off);
        logic [7:0] s;
        int         n;
        n = 1 << size;
        for (int b = 0; b < 8; b++)
            s[b] = (b >= int'(off)) && (b < int'(off) + n);
        return s;
    endfunction

    function automatic logic [63:0] lane_mask(logic [7:0] strb);
        logic [63:0] m;
        for (int b = 0; b < 8; b++)
            m[8*b +: 8] = {8{strb[b]}};
        return m;
    endfunction

    function automatic logic is_device(logic [31:0] a);
        return `IN_RANGE(a, `MMIO_UART_START, `MMIO_UART_END)
            || `IN_RANGE(a, `MMIO_SPICTRL_START, `MMIO_SPICTRL_END)
            || `IN_RANGE(a, `MMIO_SPI_START, `MMIO_SPI_END)
            || `IN_RANGE(a, `MMIO_CLINT_START, `MMIO_CLINT_END);
    endfunction

    function automatic logic [7:0] ref_byte(logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic fail_run(string what);
        $display("ERROR: %s", what);
        abort_run();
    endtask

    task automatic check_val(string name, logic [63:0] got, logic [63:0] want);
        if (got !== want) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
            abort_run();
        end
    endtask

    // expected response and bus traffic for one accepted request
    task automatic model_accept(mem_pkg::core_req_t req);
        mem_pkg::bus_req_t want;
        exp_resp_t         r;
        logic [7:0]        strb;
        logic [3:0]        idx;
        strb       = access_strobe(req.size, req.addr[2:0]);
        idx        = req.addr[6:3];
        want.write = (req.op == mem_pkg::mem_store);
        want.size  = req.size;
        want.addr  = req.addr - (req.addr % (32'd1 << req.size));
        want.wdata = req.wdata;
        want.wstrb = strb;
        r.is_load  = !want.write;
        r.mask     = lane_mask(strb);
        for (int b = 0; b < 8; b++)
            r.data[8*b +: 8] = ref_byte({req.addr[31:3], 3'(b)});
        if (want.write) begin
            for (int b = 0; b < 8; b++)
                if (strb[b])
                    ref_mem[{req.addr[31:3], 3'(b)}] = req.wdata[8*b +: 8];
        end
        if (is_device(req.addr)) begin
            unc_exp.push_back(want);
        end else if (want.write || !(line_valid[idx] && line_tag[idx] == req.addr[31:7])) begin
            want.size = mem_pkg::size_dword;    // cache side always moves whole dwords
            want.addr = {req.addr[31:3], 3'b000};
            dc_exp.push_back(want);
            if (!want.write) begin
                line_valid[idx] = 1'b1;
                line_tag[idx]   = req.addr[31:7];
            end
        end
        resp_exp.push_back(r);
    endtask

    always @(posedge clk) begin
        mem_pkg::bus_req_t want;
        exp_resp_t         r;
        logic              strb_known;
        if (reset) begin
            for (int i = 0; i < 16; i++)
                line_valid[i] = 1'b0;
        end else begin
            if (core_resp_valid) begin
                if (resp_exp.size() == 0)
                    fail_run("core response with no request outstanding");
                r = resp_exp.pop_front();
                if (r.is_load)
                    check_val("core_resp.rdata", core_resp.rdata & r.mask, r.data & r.mask);
            end
            if (core_req_valid && core_req_ready)
                model_accept(core_req);
            if (fence) begin
                check_val("core_req_ready", 64'(core_req_ready), 64'd1);
                for (int i = 0; i < 16; i++)
                    line_valid[i] = 1'b0;
            end
            if (bus_req_valid && bus_req_ready) begin
                strb_known = is_device(bus_req.addr);
                if (strb_known && unc_exp.size() == 0)
                    fail_run($sformatf("device transfer to 0x%h without a request",
                                       bus_req.addr));
                if (!strb_known && dc_exp.size() == 0)
                    fail_run($sformatf("cache transfer to 0x%h without a request",
                                       bus_req.addr));
                want = strb_known ? unc_exp.pop_front() : dc_exp.pop_front();
                strb_known = strb_known || want.write;
                check_val("bus_req.write", 64'(bus_req.write), 64'(want.write));
                check_val("bus_req.size", 64'(bus_req.size), 64'(want.size));
                check_val("bus_req.addr", 64'(bus_req.addr), 64'(want.addr));
                if (strb_known)
                    check_val("bus_req.wstrb", 64'(bus_req.wstrb), 64'(want.wstrb));
                if (want.write)
                    check_val("bus_req.wdata", bus_req.wdata & lane_mask(want.wstrb),
                              want.wdata & lane_mask(want.wstrb));
            end
        end
    end

    // bus memory with random stalls and a response 1 to max_bus_delay cycles after accept
    always @(posedge clk) begin
        logic        busy;
        int          wait_cycles;
        logic [63:0] rdata;
        logic [63:0] word;
        logic [28:0] dw;
        if (reset) begin
            bus_req_ready  <= 1'b0;
            bus_resp_valid <= 1'b0;
            busy = 1'b0;
        end else begin
            bus_resp_valid <= 1'b0;
            bus_req_ready  <= ($urandom_range(3) != 0);
            if (busy) begin
                if (wait_cycles == 0) begin
                    bus_resp_valid <= 1'b1;
                    bus_resp.rdata <= rdata;
                    busy = 1'b0;
                end else begin
                    wait_cycles = wait_cycles - 1;
                end
            end
            if (bus_req_valid && bus_req_ready) begin
                dw   = bus_req.addr[31:3];
                word = bus_mem.exists(dw) ? bus_mem[dw] : fill_dword(dw);
                for (int b = 0; b < 8; b++)
                    if (bus_req.write && bus_req.wstrb[b])
                        word[8*b +: 8] = bus_req.wdata[8*b +: 8];
                bus_mem[dw] = word;
                rdata       = word;
                busy        = 1'b1;
                wait_cycles = int'($urandom_range(max_bus_delay - 1));
            end
        end
    end

    function automatic mem_pkg::core_req_t random_request();
        mem_pkg::core_req_t req;
        int                 pick;
        logic [2:0]         sel;
        logic [1:0]         size;
        logic [2:0]         off;
        logic [31:0]        base;
        pick = int'($urandom_range(99));
        sel  = 3'($urandom_range(7));
        if (pick < 60)      // 8 dwords over 4 lines with two tags each
            base = `RAM_START + 32'(sel[1:0]) * 32'd8 + 32'(sel[2]) * 32'h400;
        else if (pick < 85)
            base = `MMIO_UART_START + 32'(sel[1:0]) * 32'd8;
        else
            base = `MMIO_CLINT_START + (sel[0] ? 32'hbff8 : 32'h4000);
        size = 2'($urandom_range(3));
        off  = 3'($urandom_range(7)) & ~3'((1 << size) - 1);
        req.op    = ($urandom_range(1) == 0) ? mem_pkg::mem_load : mem_pkg::mem_store;
        req.size  = mem_pkg::mem_size_e'(size);
        req.addr  = base + 32'(off);
        req.wdata = {$urandom, $urandom};
        return req;
    endfunction

    task automatic send_request(mem_pkg::core_req_t req);
        core_req       <= req;
        core_req_valid <= 1'b1;
        @(posedge clk);
        while (!core_req_ready)
            @(posedge clk);
        core_req_valid <= 1'b0;
        @(posedge clk);
        while (!core_resp_valid)
            @(posedge clk);
    endtask

    task automatic pulse_fence();
        core_req.op <= mem_pkg::mem_load;   // keeps the cache ready while idle
        fence       <= 1'b1;
        @(posedge clk);
        fence       <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        fail_run("watchdog expired before all requests completed");
    end

    initial begin
        void'($urandom(28));
        reset          = 1'b1;
        fence          = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < num_requests; n++) begin
            if ($urandom_range(99) < 3)
                pulse_fence();
            send_request(random_request());
            repeat ($urandom_range(2)) @(posedge clk);
        end
        while (unc_exp.size() != 0 || dc_exp.size() != 0)   // last posted store drains
            @(posedge clk);
        repeat (10) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule
